//--- verilog/bg_pkg.sv
package bg_pkg;

    // visible area
    localparam int HOR_PIXELS = 1024;
    localparam int VER_PIXELS = 768;

    localparam int COORD_W = 11;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [11:0]        rgb_t;

    // 4 bits per channel, r g b
    localparam rgb_t COLOR_BLACK    = 12'h0_0_0;
    localparam rgb_t COLOR_PLATFORM = 12'h1_1_1;
    localparam rgb_t COLOR_GRASS    = 12'h0_b_0;
    localparam rgb_t COLOR_WOOD     = 12'h8_5_2;
    localparam rgb_t COLOR_ROOF     = 12'ha_1_0;
    localparam rgb_t COLOR_WALL     = 12'hc_c_c;
    localparam rgb_t COLOR_GLASS    = 12'hd_d_f;
    localparam rgb_t COLOR_DOOR     = 12'h7_4_1;
    localparam rgb_t COLOR_HANDLE   = 12'he_e_e;
    localparam rgb_t COLOR_SKY      = 12'h0_a_f;

    typedef struct packed {
        coord_t x_start;
        coord_t x_end;
        coord_t y_start;
        coord_t y_end;
    } rect_t;

    localparam int NUM_PLATFORMS = 6;

    // x_start, x_end, y_start, y_end
    localparam rect_t PLATFORMS [NUM_PLATFORMS] = '{
        '{11'd100, 11'd300,  11'd600, 11'd620},
        '{11'd400, 11'd600,  11'd450, 11'd470},
        '{11'd700, 11'd900,  11'd500, 11'd520},
        '{11'd200, 11'd400,  11'd350, 11'd370},
        '{11'd600, 11'd800,  11'd200, 11'd220},
        '{11'd850, 11'd1000, 11'd100, 11'd120}
    };

    // rows of the 3d edge drawn above each platform
    localparam int LEDGE_ROWS = 3;

    // grass and fence
    localparam coord_t GRASS_TOP       = 11'd550;
    localparam coord_t FENCE_TOP       = 11'd300;
    localparam coord_t FENCE_LEFT      = 11'd1;
    localparam coord_t FENCE_RIGHT     = 11'd500;
    localparam coord_t FENCE_POST_STEP = 11'd100;

    // house body
    localparam coord_t HOUSE_TOP   = 11'd250;
    localparam coord_t HOUSE_LEFT  = 11'd650;
    localparam coord_t ROOF_BOTTOM = 11'd300;

    localparam rect_t WINDOW = '{
        x_start: 11'd705,
        x_end:   11'd825,
        y_start: 11'd330,
        y_end:   11'd450
    };
    localparam coord_t WINDOW_BAR_X = 11'd765;
    localparam coord_t WINDOW_BAR_Y = 11'd390;

    localparam coord_t DOOR_LEFT = 11'd910;
    localparam coord_t DOOR_TOP  = 11'd350;

    // handle is a short post plus a horizontal grip
    localparam coord_t HANDLE_X          = 11'd915;
    localparam coord_t HANDLE_RIGHT      = 11'd925;
    localparam coord_t HANDLE_TOP        = 11'd448;
    localparam coord_t HANDLE_GRIP_LAST  = 11'd449;
    localparam coord_t HANDLE_POST_LAST  = 11'd451;

    typedef enum logic [3:0] {
        OBJ_NONE,
        OBJ_GRASS,
        OBJ_GRASS_EDGE,
        OBJ_FENCE,
        OBJ_FENCE_LINE,
        OBJ_ROOF,
        OBJ_WALL,
        OBJ_OUTLINE,
        OBJ_GLASS,
        OBJ_FRAME,
        OBJ_DOOR,
        OBJ_HANDLE
    } scenery_obj_t;

endpackage

//--- verilog/vga_bus.sv
interface vga_bus;

    import bg_pkg::*;

    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;

    modport src (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    // read side, used by the layers and the compositor
    modport dst (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

//--- verilog/platform_layer.sv
module platform_layer (
    input  logic        clk,
    input  logic        rst,
    vga_bus.dst         pix,
    output logic        plat_hit,
    output bg_pkg::rgb_t plat_rgb
);

    import bg_pkg::*;

    logic fill_hit;
    logic ledge_hit;

    // fill of any platform wins over the ledge of any other
    always_comb begin
        fill_hit  = 1'b0;
        ledge_hit = 1'b0;

        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if ((pix.hcount > PLATFORMS[i].x_start) &&
                (pix.hcount < PLATFORMS[i].x_end) &&
                (pix.vcount > PLATFORMS[i].y_start) &&
                (pix.vcount < PLATFORMS[i].y_end)) begin
                fill_hit = 1'b1;
            end

            // each ledge row above is shifted one pixel right
            for (int k = 0; k < LEDGE_ROWS; k++) begin
                if ((pix.vcount == PLATFORMS[i].y_start - k) &&
                    (pix.hcount > PLATFORMS[i].x_start + k + 1) &&
                    (pix.hcount < PLATFORMS[i].x_end + k + 1)) begin
                    ledge_hit = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            plat_hit <= 1'b0;
            plat_rgb <= COLOR_BLACK;
        end else begin
            plat_hit <= fill_hit || ledge_hit;
            if (fill_hit) begin
                plat_rgb <= COLOR_PLATFORM;
            end else begin
                plat_rgb <= COLOR_BLACK;
            end
        end
    end

endmodule

//--- verilog/scenery_layer.sv
module scenery_layer (
    input  logic         clk,
    input  logic         rst,
    vga_bus.dst          pix,
    output logic         scen_hit,
    output bg_pkg::rgb_t scen_rgb
);

    import bg_pkg::*;

    scenery_obj_t obj;
    rgb_t         obj_rgb;

    logic in_grass;
    logic in_fence;
    logic in_house;
    logic in_window;
    logic in_door;
    logic on_handle;

    assign in_grass = (pix.vcount >= GRASS_TOP);

    assign in_fence = (pix.vcount >= FENCE_TOP) && (pix.vcount <= GRASS_TOP) &&
                      (pix.hcount >= FENCE_LEFT) && (pix.hcount <= FENCE_RIGHT);

    assign in_house = (pix.vcount >= HOUSE_TOP) && (pix.vcount <= GRASS_TOP) &&
                      (pix.hcount >= HOUSE_LEFT);

    assign in_window = (pix.hcount >= WINDOW.x_start) && (pix.hcount <= WINDOW.x_end) &&
                       (pix.vcount >= WINDOW.y_start) && (pix.vcount <= WINDOW.y_end);

    assign in_door = (pix.hcount >= DOOR_LEFT) &&
                     (pix.vcount >= DOOR_TOP) && (pix.vcount < GRASS_TOP);

    assign on_handle = ((pix.vcount >= HANDLE_TOP) && (pix.vcount <= HANDLE_POST_LAST) &&
                        (pix.hcount == HANDLE_X)) ||
                       ((pix.vcount >= HANDLE_TOP) && (pix.vcount <= HANDLE_GRIP_LAST) &&
                        (pix.hcount >= HANDLE_X) && (pix.hcount <= HANDLE_RIGHT));

    // priority grass, fence, house
    always_comb begin
        obj = OBJ_NONE;
        if (in_grass) begin
            obj = (pix.vcount == GRASS_TOP) ? OBJ_GRASS_EDGE : OBJ_GRASS;
        end else if (in_fence) begin
            if ((pix.vcount == GRASS_TOP - 1) || (pix.hcount == FENCE_LEFT) ||
                (pix.hcount == FENCE_RIGHT) || (pix.hcount % FENCE_POST_STEP == 0)) begin
                obj = OBJ_FENCE_LINE;
            end else begin
                obj = OBJ_FENCE;
            end
        end else if (in_house) begin
            if (pix.vcount < ROOF_BOTTOM) begin
                obj = OBJ_ROOF;
            end else if ((pix.hcount == HOUSE_LEFT) || (pix.vcount == ROOF_BOTTOM)) begin
                obj = OBJ_OUTLINE;
            end else if (in_window) begin
                if ((pix.hcount == WINDOW.x_start) || (pix.hcount == WINDOW.x_end) ||
                    (pix.vcount == WINDOW.y_start) || (pix.vcount == WINDOW.y_end) ||
                    (pix.hcount == WINDOW_BAR_X) || (pix.vcount == WINDOW_BAR_Y)) begin
                    obj = OBJ_FRAME;
                end else begin
                    obj = OBJ_GLASS;
                end
            end else if (in_door) begin
                // left and top door edge drawn like the outline
                if ((pix.hcount == DOOR_LEFT) || (pix.vcount == DOOR_TOP)) begin
                    obj = OBJ_OUTLINE;
                end else if (on_handle) begin
                    obj = OBJ_HANDLE;
                end else begin
                    obj = OBJ_DOOR;
                end
            end else begin
                obj = OBJ_WALL;
            end
        end
    end

    always_comb begin
        case (obj)
            OBJ_GRASS:  obj_rgb = COLOR_GRASS;
            OBJ_FENCE:  obj_rgb = COLOR_WOOD;
            OBJ_ROOF:   obj_rgb = COLOR_ROOF;
            OBJ_WALL:   obj_rgb = COLOR_WALL;
            OBJ_GLASS:  obj_rgb = COLOR_GLASS;
            OBJ_DOOR:   obj_rgb = COLOR_DOOR;
            OBJ_HANDLE: obj_rgb = COLOR_HANDLE;
            default:    obj_rgb = COLOR_BLACK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scen_hit <= 1'b0;
            scen_rgb <= COLOR_BLACK;
        end else begin
            scen_hit <= (obj != OBJ_NONE);
            scen_rgb <= obj_rgb;
        end
    end

endmodule

//--- verilog/bg_compose.sv
module bg_compose (
    input  logic         clk,
    input  logic         rst,
    vga_bus.dst          pix,
    input  logic         plat_hit,
    input  bg_pkg::rgb_t plat_rgb,
    input  logic         scen_hit,
    input  bg_pkg::rgb_t scen_rgb,
    vga_bus.src          out
);

    import bg_pkg::*;

    coord_t hcount_d;
    coord_t vcount_d;
    logic   hsync_d;
    logic   vsync_d;
    logic   hblnk_d;
    logic   vblnk_d;
    rgb_t   rgb_nxt;

    // first stage lines the timing up with the layer registers
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_d <= '0;
            vcount_d <= '0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
            hblnk_d  <= 1'b0;
            vblnk_d  <= 1'b0;
        end else begin
            hcount_d <= pix.hcount;
            vcount_d <= pix.vcount;
            hsync_d  <= pix.hsync;
            vsync_d  <= pix.vsync;
            hblnk_d  <= pix.hblnk;
            vblnk_d  <= pix.vblnk;
        end
    end

    always_comb begin
        if (hblnk_d || vblnk_d) begin
            rgb_nxt = COLOR_BLACK;
        end else if ((hcount_d == 0) || (hcount_d == HOR_PIXELS - 1) ||
                     (vcount_d == 0) || (vcount_d == VER_PIXELS - 1)) begin
            // frame border
            rgb_nxt = COLOR_BLACK;
        end else if (plat_hit) begin
            rgb_nxt = plat_rgb;
        end else if (scen_hit) begin
            rgb_nxt = scen_rgb;
        end else begin
            rgb_nxt = COLOR_SKY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= hcount_d;
            out.vcount <= vcount_d;
            out.hsync  <= hsync_d;
            out.vsync  <= vsync_d;
            out.hblnk  <= hblnk_d;
            out.vblnk  <= vblnk_d;
            out.rgb    <= rgb_nxt;
        end
    end

endmodule

//--- verilog/bg_top.sv
module bg_top (
    input  logic           clk,
    input  logic           rst,
    input  bg_pkg::coord_t hcount,
    input  bg_pkg::coord_t vcount,
    input  logic           hsync,
    input  logic           vsync,
    input  logic           hblnk,
    input  logic           vblnk,
    output bg_pkg::coord_t hcount_out,
    output bg_pkg::coord_t vcount_out,
    output logic           hsync_out,
    output logic           vsync_out,
    output logic           hblnk_out,
    output logic           vblnk_out,
    output bg_pkg::rgb_t   rgb
);

    vga_bus bus_in ();
    vga_bus bus_out ();

    logic         plat_hit;
    bg_pkg::rgb_t plat_rgb;
    logic         scen_hit;
    bg_pkg::rgb_t scen_rgb;

    // raw timing stream carries no colour yet
    assign bus_in.hcount = hcount;
    assign bus_in.vcount = vcount;
    assign bus_in.hsync  = hsync;
    assign bus_in.vsync  = vsync;
    assign bus_in.hblnk  = hblnk;
    assign bus_in.vblnk  = vblnk;
    assign bus_in.rgb    = '0;

    platform_layer u_platform_layer (
        .clk      (clk),
        .rst      (rst),
        .pix      (bus_in.dst),
        .plat_hit (plat_hit),
        .plat_rgb (plat_rgb)
    );

    scenery_layer u_scenery_layer (
        .clk      (clk),
        .rst      (rst),
        .pix      (bus_in.dst),
        .scen_hit (scen_hit),
        .scen_rgb (scen_rgb)
    );

    bg_compose u_bg_compose (
        .clk      (clk),
        .rst      (rst),
        .pix      (bus_in.dst),
        .plat_hit (plat_hit),
        .plat_rgb (plat_rgb),
        .scen_hit (scen_hit),
        .scen_rgb (scen_rgb),
        .out      (bus_out.src)
    );

    assign hcount_out = bus_out.hcount;
    assign vcount_out = bus_out.vcount;
    assign hsync_out  = bus_out.hsync;
    assign vsync_out  = bus_out.vsync;
    assign hblnk_out  = bus_out.hblnk;
    assign vblnk_out  = bus_out.vblnk;
    assign rgb        = bus_out.rgb;

endmodule

//--- testbench/bg_properties.sv
module bg_properties (
    input logic           clk,
    input logic           rst,
    input logic           hsync_in,
    input logic           vsync_in,
    input logic           plat_hit,
    input logic           scen_hit,
    input bg_pkg::coord_t hcount_out,
    input bg_pkg::coord_t vcount_out,
    input logic           hsync_out,
    input logic           vsync_out,
    input logic           hblnk_out,
    input logic           vblnk_out,
    input bg_pkg::rgb_t   rgb_out
);

    timeunit 1ns;
    timeprecision 100ps;

    import bg_pkg::*;

    reset_clears: assert property (@(posedge clk) $past(rst) |->
        (hcount_out == '0) && (vcount_out == '0) && !hsync_out && !vsync_out &&
        !hblnk_out && !vblnk_out && (rgb_out == COLOR_BLACK) && !plat_hit && !scen_hit)
        else $error("outputs or hit flags not cleared after reset");

    // syncs pass through both register stages untouched
    sync_latency: assert property (@(posedge clk) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2)) |->
        (hsync_out == $past(hsync_in, 2)) && (vsync_out == $past(vsync_in, 2)))
        else $error("output syncs do not match inputs of two cycles before");

    blank_is_black: assert property (@(posedge clk) disable iff (rst)
        (hblnk_out || vblnk_out) |-> (rgb_out == COLOR_BLACK))
        else $error("rgb not black during blanking");

endmodule

bind bg_compose bg_properties u_bg_properties (
    .clk        (clk),
    .rst        (rst),
    .hsync_in   (pix.hsync),
    .vsync_in   (pix.vsync),
    .plat_hit   (plat_hit),
    .scen_hit   (scen_hit),
    .hcount_out (out.hcount),
    .vcount_out (out.vcount),
    .hsync_out  (out.hsync),
    .vsync_out  (out.vsync),
    .hblnk_out  (out.hblnk),
    .vblnk_out  (out.vblnk),
    .rgb_out    (out.rgb)
);

//--- testbench/tb_bg.sv
module tb_bg;

    timeunit 1ns;
    timeprecision 100ps;

    import bg_pkg::*;

    localparam int MAX_PIX    = 64;
    localparam int RST_CYCLES = 4;

    logic   clk;
    logic   rst;
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    coord_t hcount_out;
    coord_t vcount_out;
    logic   hsync_out;
    logic   vsync_out;
    logic   hblnk_out;
    logic   vblnk_out;
    rgb_t   rgb;

    // five words per pixel, see the trace header
    logic [11:0] trace_mem [5*MAX_PIX];
    logic [1:0]  sync_sent [MAX_PIX];

    int num_pix     = 0;
    int cycle_limit = 5 * MAX_PIX;
    int cycles      = 0;
    int checks      = 0;
    int errors      = 0;
    int seed        = 32'h9c05_feb4;

    bg_top UUT (
        .clk        (clk),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .hcount_out (hcount_out),
        .vcount_out (vcount_out),
        .hsync_out  (hsync_out),
        .vsync_out  (vsync_out),
        .hblnk_out  (hblnk_out),
        .vblnk_out  (vblnk_out),
        .rgb        (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs(input string tag, input logic [11:0] h, input logic [11:0] v,
                                 input logic [1:0] sync, input logic hb, input logic vb,
                                 input logic [11:0] colour);
        compare({tag, " hcount_out"}, hcount_out, h);
        compare({tag, " vcount_out"}, vcount_out, v);
        compare({tag, " hsync_out"}, hsync_out, sync[0]);
        compare({tag, " vsync_out"}, vsync_out, sync[1]);
        compare({tag, " hblnk_out"}, hblnk_out, hb);
        compare({tag, " vblnk_out"}, vblnk_out, vb);
        compare({tag, " rgb"}, rgb, colour);
    endtask

    task automatic drive_pixel(input int p);
        hcount <= trace_mem[5*p][COORD_W-1:0];
        vcount <= trace_mem[5*p+1][COORD_W-1:0];
        hblnk  <= trace_mem[5*p+2][0];
        vblnk  <= trace_mem[5*p+3][0];
        hsync  <= sync_sent[p][0];
        vsync  <= sync_sent[p][1];
    endtask

    initial begin
        int r;
        rst    = 1'b1;
        hcount = '0;
        vcount = '0;
        hsync  = 1'b0;
        vsync  = 1'b0;
        hblnk  = 1'b0;
        vblnk  = 1'b0;

        $readmemh("testbench/bg_trace.txt", trace_mem);
        // hcount word fff ends the trace
        while ((num_pix < MAX_PIX) && (trace_mem[5*num_pix] !== 12'hfff)) begin
            r = $random(seed);
            sync_sent[num_pix] = r[1:0];
            num_pix++;
        end
        cycle_limit = num_pix + RST_CYCLES + 10;
        if (num_pix == 0) begin
            errors++;
            $display("trace file testbench/bg_trace.txt holds no pixels");
        end

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs("after reset", 12'h0, 12'h0, 2'b00, 1'b0, 1'b0, 12'h0);

        // two pixels in flight, so checks trail the drive by two cycles
        for (int c = 0; c < num_pix + 2; c++) begin
            int p;
            p = c - 2;
            @(posedge clk);
            if (c < num_pix) begin
                drive_pixel(c);
            end
            @(negedge clk);
            if (p >= 0) begin
                check_outputs($sformatf("pixel %0d", p), trace_mem[5*p], trace_mem[5*p+1],
                              sync_sent[p], trace_mem[5*p+2][0], trace_mem[5*p+3][0],
                              trace_mem[5*p+4]);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- testbench/bg_trace.txt
// columns: hcount vcount hblnk vblnk expected_rgb, all hex
// one pixel per line, hcount fff marks the end
0c8 262 1 0 000 // hblnk over platform 0
0c8 262 0 1 000 // vblnk over platform 0
000 262 0 0 000 // left border
3ff 12c 0 0 000 // right border
1f4 000 0 0 000 // top border
1f4 2ff 0 0 000 // bottom border
0c8 262 0 0 111 // platform 0 fill over grass
0c8 258 0 0 000 // platform 0 ledge top row
12d 258 0 0 0b0 // just right of that ledge row
12e 256 0 0 000 // third ledge row, shifted right
1f4 1cc 0 0 111 // platform 1 over fence line
226 1c1 0 0 000 // platform 1 ledge in open sky
2bc 0d2 0 0 111 // platform 4
384 06e 0 0 111 // platform 5
352 06e 0 0 0af // platform 5 left edge, open
258 2bc 0 0 0b0 // grass
2bc 226 0 0 000 // grass edge row
096 190 0 0 852 // fence wood
096 12c 0 0 852 // fence top row
096 225 0 0 000 // fence bottom rail
12c 1a4 0 0 000 // fence post
001 1a4 0 0 000 // fence left end
1f4 140 0 0 000 // fence right end
096 12b 0 0 0af // above fence
1f5 190 0 0 0af // right of fence
2bc 10e 0 0 a10 // roof
294 0fa 0 0 a10 // roof top row
294 0f9 0 0 0af // above roof
28a 190 0 0 000 // house left outline
2bc 12c 0 0 000 // outline under roof
2a8 190 0 0 ccc // wall
2df 168 0 0 ddf // window glass
2c1 168 0 0 000 // window frame
2fd 168 0 0 000 // vertical bar
2df 186 0 0 000 // horizontal bar
3b6 190 0 0 741 // door
38e 190 0 0 000 // door left edge
3b6 15e 0 0 000 // door top edge
393 1c3 0 0 eee // handle post bottom
39d 1c0 0 0 eee // handle grip end
39e 1c0 0 0 741 // past the grip
1f4 032 0 0 0af // open sky
fff 000 0 0 000 // end marker

//--- files.f
verilog/bg_pkg.sv
verilog/vga_bus.sv
verilog/platform_layer.sv
verilog/scenery_layer.sv
verilog/bg_compose.sv
verilog/bg_top.sv
testbench/bg_properties.sv
testbench/tb_bg.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bg
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
